//--- design/firPkg.sv
package firPkg;

  ////////////////////////////////////////////////////////////
  // widths and tap count
  ////////////////////////////////////////////////////////////
  localparam int numTaps     = 8;
  localparam int tapIdxWidth = $clog2(numTaps);
  localparam int sampleWidth = 16;  // sfix16_En15
  localparam int coeffWidth  = 16;  // sfix16_En16
  localparam int prodWidth   = sampleWidth + coeffWidth;  // sfix32_En31
  localparam int accWidth    = prodWidth + 1;  // sfix33_En31

  typedef logic        [tapIdxWidth-1:0] tapIdxT;
  typedef logic signed [sampleWidth-1:0] sampleT;
  typedef logic signed [coeffWidth-1:0]  coeffT;
  typedef logic signed [prodWidth-1:0]   productT;
  typedef logic signed [accWidth-1:0]    accT;

  ////////////////////////////////////////////////////////////
  // coefficient table
  ////////////////////////////////////////////////////////////
  // symmetric low-pass taps, tap 0 first
  localparam coeffT coeffTable [numTaps] = '{
    16'shDDBB,
    16'shEA8E,
    16'sh33DB,
    16'sh6808,
    16'sh6808,
    16'sh33DB,
    16'shEA8E,
    16'shDDBB
  };

  ////////////////////////////////////////////////////////////
  // one tap issued to the MAC
  ////////////////////////////////////////////////////////////
  typedef struct packed {
    sampleT tapSample;  // delay-line word for this tap
    tapIdxT tapIdx;     // coefficient index
    logic   firstTap;   // tap 0, restart accumulation
    logic   lastTap;    // tap 7, new sample enters
    logic   beatValid;  // enabled cycle
  } tapBeatT;

endpackage

//--- design/carrySelectAdder.sv
`timescale 1ns/10ps

module carrySelectAdder #(
  parameter int addWidth   = 33,
  parameter int blockWidth = 5
) (
  input  logic [addWidth-1:0] addA,
  input  logic [addWidth-1:0] addB,
  input  logic                carryIn,
  output logic [addWidth-1:0] sum,
  output logic                carryOut
);

  localparam int numBlocks = (addWidth + blockWidth - 1) / blockWidth;

  logic [addWidth-1:0] bitProp;
  logic [addWidth-1:0] bitGen;
  logic [numBlocks:0]  blockCarry;

  assign bitProp       = addA ^ addB;
  assign bitGen        = addA & addB;
  assign blockCarry[0] = carryIn;
  assign carryOut      = blockCarry[numBlocks];

  for (genvar b = 0; b < numBlocks; b++) begin : g_block
    localparam int lo = b * blockWidth;
    localparam int bw = (addWidth - lo < blockWidth) ? (addWidth - lo) : blockWidth;

    if (b == 0) begin : g_ripple
      logic [bw-1:0] blockSum;
      logic          blockCout;

      always_comb begin
        logic carry;
        carry = blockCarry[0];
        for (int i = 0; i < bw; i++) begin
          blockSum[i] = bitProp[lo+i] ^ carry;
          carry       = bitGen[lo+i] | (bitProp[lo+i] & carry);
        end
        blockCout = carry;
      end

      assign sum[lo +: bw]     = blockSum;
      assign blockCarry[b + 1] = blockCout;
    end else begin : g_select
      logic [bw-1:0] sumIfLow, sumIfHigh;
      logic          coutIfLow, coutIfHigh;

      // both carry assumptions in parallel
      always_comb begin
        logic carryLow, carryHigh;
        carryLow  = 1'b0;
        carryHigh = 1'b1;
        for (int i = 0; i < bw; i++) begin
          sumIfLow[i]  = bitProp[lo+i] ^ carryLow;
          sumIfHigh[i] = bitProp[lo+i] ^ carryHigh;
          carryLow     = bitGen[lo+i] | (bitProp[lo+i] & carryLow);
          carryHigh    = bitGen[lo+i] | (bitProp[lo+i] & carryHigh);
        end
        coutIfLow  = carryLow;
        coutIfHigh = carryHigh;
      end

      assign sum[lo +: bw]     = blockCarry[b] ? sumIfHigh : sumIfLow;
      assign blockCarry[b + 1] = blockCarry[b] ? coutIfHigh : coutIfLow;
    end
  end

endmodule

//--- design/vedicMultiplier.sv
`timescale 1ns/10ps

module vedicMultiplier #(
  parameter int opWidth   = 16,
  parameter bit signedOps = 1'b1
) (
  input  logic signed [opWidth-1:0]   multA,
  input  logic signed [opWidth-1:0]   multB,
  output logic signed [2*opWidth-1:0] product
);

  logic [opWidth-1:0]   magA;
  logic [opWidth-1:0]   magB;
  logic [2*opWidth-1:0] magProduct;

  ////////////////////////////////////////////////////////////
  // sign handling, outermost level only
  ////////////////////////////////////////////////////////////
  if (signedOps) begin : g_signed
    logic negResult;

    assign magA      = multA[opWidth-1] ? -multA : multA;  // -min fits unsigned
    assign magB      = multB[opWidth-1] ? -multB : multB;
    assign negResult = multA[opWidth-1] ^ multB[opWidth-1];
    assign product   = negResult ? -magProduct : magProduct;
  end else begin : g_unsigned
    assign magA    = multA;
    assign magB    = multB;
    assign product = magProduct;
  end

  ////////////////////////////////////////////////////////////
  // magnitude array
  ////////////////////////////////////////////////////////////
  if (opWidth == 2) begin : g_base
    logic crossCarry;

    // 2x2 cell, two half adders
    assign magProduct[0] = magA[0] & magB[0];
    assign magProduct[1] = (magA[1] & magB[0]) ^ (magA[0] & magB[1]);
    assign crossCarry    = (magA[1] & magB[0]) & (magA[0] & magB[1]);
    assign magProduct[2] = (magA[1] & magB[1]) ^ crossCarry;
    assign magProduct[3] = (magA[1] & magB[1]) & crossCarry;
  end else begin : g_split
    localparam int half       = opWidth / 2;
    localparam int mergeBlock = half / 2 + 1;

    logic [opWidth-1:0]      prodLL, prodHL, prodLH, prodHH;
    logic [opWidth-1:0]      midLow;
    logic [opWidth+half-1:0] midHigh;
    logic [opWidth+half-1:0] upperSum;

    vedicMultiplier #(.opWidth(half), .signedOps(1'b0)) i_multLL (
      .multA(magA[half-1:0]), .multB(magB[half-1:0]), .product(prodLL)
    );
    vedicMultiplier #(.opWidth(half), .signedOps(1'b0)) i_multHL (
      .multA(magA[opWidth-1:half]), .multB(magB[half-1:0]), .product(prodHL)
    );
    vedicMultiplier #(.opWidth(half), .signedOps(1'b0)) i_multLH (
      .multA(magA[half-1:0]), .multB(magB[opWidth-1:half]), .product(prodLH)
    );
    vedicMultiplier #(.opWidth(half), .signedOps(1'b0)) i_multHH (
      .multA(magA[opWidth-1:half]), .multB(magB[opWidth-1:half]), .product(prodHH)
    );

    // upper half of LL plus HL, never overflows opWidth
    carrySelectAdder #(.addWidth(opWidth), .blockWidth(mergeBlock)) i_addLow (
      .addA({{half{1'b0}}, prodLL[opWidth-1:half]}), .addB(prodHL),
      .carryIn(1'b0), .sum(midLow), .carryOut()
    );
    carrySelectAdder #(.addWidth(opWidth + half), .blockWidth(mergeBlock)) i_addCross (
      .addA({{half{1'b0}}, prodLH}), .addB({prodHH, {half{1'b0}}}),
      .carryIn(1'b0), .sum(midHigh), .carryOut()
    );
    carrySelectAdder #(.addWidth(opWidth + half), .blockWidth(mergeBlock)) i_addMerge (
      .addA({{half{1'b0}}, midLow}), .addB(midHigh),
      .carryIn(1'b0), .sum(upperSum), .carryOut()
    );

    assign magProduct = {upperSum, prodLL[half-1:0]};
  end

endmodule

//--- design/tapSequencer.sv
`timescale 1ns/10ps

module tapSequencer (
  input  logic             clk,
  input  logic             reset,
  input  logic             clkEnable,
  input  firPkg::sampleT   filterIn,
  output firPkg::tapBeatT  tapBeat
);

  localparam firPkg::tapIdxT lastIdx = firPkg::tapIdxT'(firPkg::numTaps - 1);

  firPkg::tapIdxT phaseCount;
  firPkg::sampleT delayLine [firPkg::numTaps];
  logic           lastPhase;
  logic           shiftIn;

  assign lastPhase = (phaseCount == lastIdx);
  assign shiftIn   = clkEnable & lastPhase;

  ////////////////////////////////////////////////////////////
  // phase counter
  ////////////////////////////////////////////////////////////
  always_ff @(posedge clk or posedge reset) begin
    if (reset) begin
      phaseCount <= lastIdx;  // first enabled edge takes a sample
    end else if (clkEnable) begin
      if (lastPhase) begin
        phaseCount <= '0;
      end else begin
        phaseCount <= phaseCount + 1'b1;
      end
    end
  end

  ////////////////////////////////////////////////////////////
  // sample delay line
  ////////////////////////////////////////////////////////////
  always_ff @(posedge clk or posedge reset) begin
    if (reset) begin
      for (int i = 0; i < firPkg::numTaps; i++) begin
        delayLine[i] <= '0;
      end
    end else if (shiftIn) begin
      for (int i = firPkg::numTaps - 1; i > 0; i--) begin
        delayLine[i] <= delayLine[i-1];
      end
      delayLine[0] <= filterIn;  // newest sample at tap 0
    end
  end

  // tap k is presented while the counter sits at k
  always_comb begin
    tapBeat.tapSample = delayLine[phaseCount];
    tapBeat.tapIdx    = phaseCount;
    tapBeat.firstTap  = clkEnable & (phaseCount == '0);
    tapBeat.lastTap   = shiftIn;
    tapBeat.beatValid = clkEnable;
  end

endmodule

//--- design/macAccumulator.sv
`timescale 1ns/10ps

module macAccumulator #(
  parameter int adderBlock = 5
) (
  input  logic            clk,
  input  logic            reset,
  input  firPkg::tapBeatT tapBeat,
  output firPkg::accT     filterOut
);

  firPkg::coeffT   tapCoeff;
  firPkg::productT tapProduct;
  firPkg::accT     productExt;
  firPkg::accT     accReg;
  firPkg::accT     accSum;
  firPkg::accT     accNext;
  firPkg::accT     finalSum;

  ////////////////////////////////////////////////////////////
  // coefficient select and multiply
  ////////////////////////////////////////////////////////////
  assign tapCoeff = firPkg::coeffTable[tapBeat.tapIdx];

  vedicMultiplier #(
    .opWidth  ($bits(firPkg::sampleT)),
    .signedOps(1'b1)
  ) i_vedicMultiplier (
    .multA  (tapBeat.tapSample),
    .multB  (tapCoeff),
    .product(tapProduct)
  );

  assign productExt = firPkg::accT'(tapProduct);  // sign extend to En31 acc

  ////////////////////////////////////////////////////////////
  // accumulate
  ////////////////////////////////////////////////////////////
  carrySelectAdder #(
    .addWidth  ($bits(firPkg::accT)),
    .blockWidth(adderBlock)
  ) i_accAdder (
    .addA    (productExt),
    .addB    (accReg),
    .carryIn (1'b0),
    .sum     (accSum),
    .carryOut()
  );

  assign accNext = tapBeat.firstTap ? productExt : accSum;  // restart on tap 0

  always_ff @(posedge clk or posedge reset) begin
    if (reset) begin
      accReg <= '0;
    end else if (tapBeat.beatValid) begin
      accReg <= accNext;
    end
  end

  ////////////////////////////////////////////////////////////
  // final sum and output registers
  ////////////////////////////////////////////////////////////
  always_ff @(posedge clk or posedge reset) begin
    if (reset) begin
      finalSum  <= '0;
      filterOut <= '0;
    end else if (tapBeat.beatValid) begin
      if (tapBeat.firstTap) begin
        finalSum <= accReg;  // acc holds the finished sum here
      end
      if (tapBeat.lastTap) begin
        filterOut <= finalSum;
      end
    end
  end

endmodule

//--- design/serialFir.sv
`timescale 1ns/10ps

module serialFir #(
  parameter int adderBlock = 5
) (
  input  logic           clk,
  input  logic           reset,
  input  logic           clkEnable,
  input  firPkg::sampleT filterIn,
  output firPkg::accT    filterOut
);

  ////////////////////////////////////////////////////////////
  // input side to processing side
  ////////////////////////////////////////////////////////////
  firPkg::tapBeatT tapBeat;  // one tap per enabled cycle

  tapSequencer i_tapSequencer (
    .clk      (clk),
    .reset    (reset),
    .clkEnable(clkEnable),
    .filterIn (filterIn),
    .tapBeat  (tapBeat)
  );

  macAccumulator #(
    .adderBlock(adderBlock)
  ) i_macAccumulator (
    .clk      (clk),
    .reset    (reset),
    .tapBeat  (tapBeat),
    .filterOut(filterOut)
  );

endmodule

//--- verif/serialFir_props.sv
`timescale 1ns/10ps

module tapStreamProps (
  input logic            clk,
  input logic            reset,
  input firPkg::tapBeatT tapBeat
);

  logic lastSeen;       // last tap waiting for its successor
  int   failCount = 0;  // assertion failures so far

  always_ff @(posedge clk or posedge reset) begin
    if (reset) begin
      lastSeen <= 1'b0;
    end else if (tapBeat.beatValid) begin
      lastSeen <= tapBeat.lastTap;
    end
  end

  ////////////////////////////////////////////////////////////
  // tap stream rules
  ////////////////////////////////////////////////////////////
  flagsExclusive: assert property (@(posedge clk) disable iff (reset)
    !(tapBeat.firstTap && tapBeat.lastTap))
    else begin
      $error("firstTap and lastTap high in the same cycle");
      failCount++;
    end

  firstAfterLast: assert property (@(posedge clk) disable iff (reset)
    (tapBeat.beatValid && lastSeen) |-> tapBeat.firstTap)
    else begin
      $error("enabled beat after lastTap is not a firstTap beat");
      failCount++;
    end

  flagsNeedValid: assert property (@(posedge clk) disable iff (reset)
    !tapBeat.beatValid |-> !(tapBeat.firstTap || tapBeat.lastTap))
    else begin
      $error("tap flag high in a disabled cycle");
      failCount++;
    end

endmodule

bind tapSequencer tapStreamProps i_tapStreamProps (
  .clk    (clk),
  .reset  (reset),
  .tapBeat(tapBeat)
);

//--- verif/serialFirTb.sv
`timescale 1ns/10ps

module serialFirTb;

  localparam int numRows   = 72;
  localparam int maxStall  = 5;
  localparam int resetCyc  = 16;
  localparam int timeoutNs = numRows * (8 + maxStall) * 10 * 2 + resetCyc * 10;

  // one sample period of stimulus and the output shown after its capture edge
  typedef struct packed {
    firPkg::sampleT sample;
    int             stall;     // disabled cycles inside the period
    firPkg::accT    expected;
  } rowT;

  logic           clk;
  logic           reset;
  logic           clkEnable;
  firPkg::sampleT filterIn;
  firPkg::accT    filterOut;

  rowT            rows [numRows];
  firPkg::sampleT shadowLine [firPkg::numTaps];
  firPkg::accT    shownOut;
  int             seed = 32507;
  int             valueErrors;
  int             timeoutErrors;
  int             assertErrors;

  serialFir #(
    .adderBlock(5)
  ) i_serialFir (
    .clk      (clk),
    .reset    (reset),
    .clkEnable(clkEnable),
    .filterIn (filterIn),
    .filterOut(filterOut)
  );

  assign assertErrors = i_serialFir.i_tapSequencer.i_tapStreamProps.failCount;

  always #5 clk = ~clk;

  ////////////////////////////////////////////////////////////
  // reference model
  ////////////////////////////////////////////////////////////
  function automatic firPkg::accT shiftAndSum(input firPkg::sampleT newSample);
    longint total;
    for (int k = firPkg::numTaps - 1; k > 0; k--) begin
      shadowLine[k] = shadowLine[k-1];
    end
    shadowLine[0] = newSample;
    total = 0;
    for (int k = 0; k < firPkg::numTaps; k++) begin
      total += longint'(firPkg::coeffTable[k]) * longint'(shadowLine[k]);
    end
    return firPkg::accT'(total);
  endfunction

  task automatic buildTable();
    logic [31:0] r;
    firPkg::accT pendingOut [$];
    for (int m = 0; m < numRows; m++) begin
      if (m == 0) begin
        rows[m].sample = 16'sh4000;  // impulse
        rows[m].stall  = 0;
      end else if (m < 10) begin
        rows[m].sample = '0;
        rows[m].stall  = 0;
      end else if (m < 20) begin
        rows[m].sample = 16'sh7FFF;  // positive full scale
        rows[m].stall  = m % 3;
      end else if (m < 30) begin
        rows[m].sample = 16'sh8000;  // negative full scale
        rows[m].stall  = m % 4;
      end else if (m < 70) begin
        r              = $random(seed);
        rows[m].sample = r[15:0];
        rows[m].stall  = int'(r[31:16]) % (maxStall + 1);
      end else begin
        rows[m].sample = '0;  // flush the last two random results
        rows[m].stall  = 1;
      end
    end
    for (int k = 0; k < firPkg::numTaps; k++) begin
      shadowLine[k] = '0;
    end
    // the capture of sample m shows y[m-2]
    for (int m = 0; m < numRows; m++) begin
      pendingOut.push_back(shiftAndSum(rows[m].sample));
      if (pendingOut.size() > 2) begin
        rows[m].expected = pendingOut.pop_front();
      end else begin
        rows[m].expected = '0;
      end
    end
  endtask

  ////////////////////////////////////////////////////////////
  // checks and stimulus
  ////////////////////////////////////////////////////////////
  task automatic checkAcc(input string name, input firPkg::accT got,
                          input firPkg::accT expected);
    if (got !== expected) begin
      $display("ERROR at %0t ns: %s is %0d, expected %0d", $time, name, got, expected);
      valueErrors++;
    end
  endtask

  // one sample period from the last-tap phase
  task automatic applyRow(input rowT row);
    @(negedge clk);
    checkAcc("filterOut", filterOut, shownOut);
    filterIn  = row.sample;
    clkEnable = 1'b1;
    shownOut  = row.expected;
    for (int i = 0; i < row.stall + 7; i++) begin
      @(negedge clk);
      checkAcc("filterOut", filterOut, shownOut);  // must hold through stalls
      filterIn  = ~row.sample;  // not captured off the last tap
      clkEnable = !(i >= 3 && i < 3 + row.stall);
    end
  endtask

  task automatic printCounts();
    $display("errors: %0d wrong values, %0d assertion failures, %0d timeouts",
             valueErrors, assertErrors, timeoutErrors);
  endtask

  ////////////////////////////////////////////////////////////
  // main sequence
  ////////////////////////////////////////////////////////////
  initial begin
    clk           = 1'b0;
    reset         = 1'b1;
    clkEnable     = 1'b0;
    filterIn      = '0;
    shownOut      = '0;
    valueErrors   = 0;
    timeoutErrors = 0;
    buildTable();
    repeat (resetCyc) @(negedge clk);
    reset = 1'b0;
    @(negedge clk);
    checkAcc("filterOut", filterOut, '0);  // nothing has passed through yet
    for (int m = 0; m < numRows; m++) begin
      applyRow(rows[m]);
    end
    @(negedge clk);
    checkAcc("filterOut", filterOut, shownOut);
    clkEnable = 1'b0;
    printCounts();
    if (valueErrors == 0 && timeoutErrors == 0 && assertErrors == 0) begin
      $display("Everything OK");
    end else begin
      $display("Something failed");
    end
    $finish;
  end

  initial begin : watchdog
    #(timeoutNs);
    timeoutErrors++;
    $display("the run timed out after %0d ns before all samples were applied", timeoutNs);
    printCounts();
    $display("Something failed");
    $finish;
  end

endmodule

//--- all.f
design/firPkg.sv
design/carrySelectAdder.sv
design/vedicMultiplier.sv
design/tapSequencer.sv
design/macAccumulator.sv
design/serialFir.sv
verif/serialFir_props.sv
verif/serialFirTb.sv

//--- run.sh
#!/bin/sh
# Build and run the serial FIR testbench with Verilator.
set -e

cd "$(dirname "$0")"

rm -rf obj_dir
verilator --binary --timing --assert \
  --top-module serialFirTb \
  -f all.f

./obj_dir/VserialFirTb | tee sim.log

if grep -qx "Everything OK" sim.log; then
  echo "simulation passed"
  exit 0
else
  echo "simulation failed"
  exit 1
fi
